//--- dv/dcacheCtrlTb.sv
// testbench for the data cache controller
// clock and reset, bus responder with xorshift delays, scenario runner
// fed from dv/stimulus_input.txt, event counts and watchdog

`timescale 1ns/1ps

module dcacheCtrlTb;

	localparam int scenarioCount = 20;
	localparam int fieldCount = 16;
	localparam int beatsPerLine = 512 / 64;
	localparam int kindRead = 1;
	localparam int kindWrite = 2;
	localparam int kindAmo = 3;
	localparam int randomDelay = 255;
	localparam int randomMax = 3;
	localparam logic [1:0] heldAdr = 2'd2;
	localparam logic [31:0] rngSeed = 32'hd830_c86d;

	logic       clk;
	logic       reset;
	logic [1:0] memRW;
	logic [1:0] atomic;
	logic       exception;
	logic       cacheable;
	logic       cacheHit;
	logic       victimDirty;
	logic       stallW;
	logic       ahbAck = 1'b0;
	logic       dcacheStall;
	logic       committed;
	logic       accessPulse;
	logic       missPulse;
	logic       ahbRead;
	logic       ahbWrite;
	logic [1:0] selAdr;
	logic       setValid;
	logic       clearDirty;
	logic       setDirty;
	logic       wordWriteEn;
	logic       blockWriteEn;
	logic       selUncached;
	logic       selEvict;
	logic       lruWriteEn;

	logic [7:0]  stimMem [0:scenarioCount*fieldCount-1];
	int          errorCount = 0;
	int          watchdogCycles = 0;
	int          delayCfg = 0;
	int          waitLeft = 0;
	logic        busSeen = 1'b0;
	logic        ackSeen = 1'b0;
	logic        armed = 1'b0;
	logic [31:0] rngState = rngSeed;

	dcacheCtrl u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string countName(input int i);
		case (i)
			0: return "accessPulse";
			1: return "missPulse";
			2: return "read beats";
			3: return "write beats";
			4: return "blockWriteEn";
			5: return "wordWriteEn";
			6: return "setDirty";
			7: return "selUncached";
			default: return "dcacheStall seen";
		endcase
	endfunction

	// worst case per scenario: every beat at the longest delay, plus stall and slack
	function automatic int watchdogLimit();
		int worstDelay;
		int worstStall;
		int d;
		worstDelay = 0;
		worstStall = 0;
		for (int s = 0; s < scenarioCount; s++) begin
			d = int'(stimMem[s*fieldCount + 6]);
			if (d == randomDelay) begin
				d = randomMax;
			end
			if (d > worstDelay) begin
				worstDelay = d;
			end
			if (int'(stimMem[s*fieldCount + 5]) > worstStall) begin
				worstStall = int'(stimMem[s*fieldCount + 5]);
			end
		end
		// a beat takes its delay, one wait cycle and the ack cycle
		return scenarioCount * (2*beatsPerLine*(worstDelay + 2) + worstStall + 20) + 4;
	endfunction

	task automatic reportMismatch(input int s, input string name, input int expected,
			input int actual);
		errorCount++;
		$display("CHECK FAILED at %0t: scenario %0d %s expected %0d got %0d",
			$time, s, name, expected, actual);
	endtask

	task automatic reportProblem(input int s, input string what);
		errorCount++;
		$display("ERROR at %0t: scenario %0d, %s", $time, s, what);
	endtask

	////////////////////////////////////////////////////////////
	// bus responder
	////////////////////////////////////////////////////////////

	// bus side sampled away from the rising edge
	always @(negedge clk) begin
		busSeen <= ahbRead || ahbWrite;
		ackSeen <= ahbAck;
	end

	always @(posedge clk) begin : busResponder
		int delay;
		if (reset || !busSeen || ackSeen) begin
			ahbAck <= 1'b0;
			armed <= 1'b0;
		end else if (!armed) begin
			// each beat picks its own delay
			if (delayCfg == randomDelay) begin
				rngState = xorshift32(rngState);
				delay = int'(rngState[1:0]);
			end else begin
				delay = delayCfg;
			end
			armed <= 1'b1;
			waitLeft <= delay;
			ahbAck <= (delay == 0);
		end else if (waitLeft > 1) begin
			waitLeft <= waitLeft - 1;
		end else begin
			ahbAck <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// scenario runner
	////////////////////////////////////////////////////////////

	task automatic runScenario(input int s);
		int base;
		int kind;
		int stallCycles;
		int cycles;
		int validCnt;
		int clearCnt;
		int lruCnt;
		int expCount [9];
		int gotCount [9];
		bit isAmo;
		bit advance;
		bit done;
		base = s * fieldCount;
		kind = int'(stimMem[base]);
		isAmo = (kind == kindAmo);
		stallCycles = int'(stimMem[base + 5]);
		delayCfg = int'(stimMem[base + 6]);
		for (int i = 0; i < 9; i++) begin
			expCount[i] = int'(stimMem[base + 7 + i]);
			gotCount[i] = 0;
		end
		validCnt = 0;
		clearCnt = 0;
		lruCnt = 0;
		cycles = 0;
		done = 1'b0;

		@(posedge clk);
		case (kind)
			kindRead: memRW <= 2'b10;
			kindWrite: memRW <= 2'b01;
			default: begin
				memRW <= 2'b11;
				atomic <= 2'b10;
			end
		endcase
		cacheable <= stimMem[base + 1][0];
		cacheHit <= stimMem[base + 2][0];
		victimDirty <= stimMem[base + 3][0];
		exception <= stimMem[base + 4][0];
		stallW <= (stallCycles > 0);

		// memory stage holds the request until it may advance
		while (!done) begin
			@(negedge clk);
			if (accessPulse) gotCount[0]++;
			if (missPulse) gotCount[1]++;
			if (ahbRead && ahbAck) gotCount[2]++;
			if (ahbWrite && ahbAck) gotCount[3]++;
			if (blockWriteEn) gotCount[4]++;
			if (wordWriteEn) gotCount[5]++;
			if (setDirty) gotCount[6]++;
			if (selUncached) gotCount[7]++;
			if (dcacheStall) gotCount[8] = 1;
			if (setValid) validCnt++;
			if (clearDirty) clearCnt++;
			if (lruWriteEn) lruCnt++;
			// cached write beats are victim beats
			if (ahbWrite && ahbAck && (selEvict != cacheable)) begin
				reportMismatch(s, "selEvict", int'(cacheable), int'(selEvict));
			end
			if (isAmo && wordWriteEn && stallW) begin
				reportProblem(s, "AMO word write while stallW is high");
			end
			if (isAmo && cycles > 0 && stallW && !committed) begin
				reportProblem(s, "committed low while the AMO waits on stallW");
			end
			if (isAmo && cycles > 0 && stallW && (selAdr != heldAdr)) begin
				reportMismatch(s, "selAdr", int'(heldAdr), int'(selAdr));
			end
			advance = !dcacheStall && !stallW;
			@(posedge clk);
			cycles++;
			stallW <= (cycles < stallCycles);
			if (advance) begin
				memRW <= 2'b00;
				atomic <= 2'b00;
				cacheable <= 1'b0;
				cacheHit <= 1'b0;
				victimDirty <= 1'b0;
				exception <= 1'b0;
				done = 1'b1;
			end
		end

		// controller must be back in ready and idle
		@(negedge clk);
		if (committed !== 1'b0) begin
			reportMismatch(s, "committed", 0, int'(committed));
		end
		if (dcacheStall !== 1'b0) begin
			reportMismatch(s, "dcacheStall", 0, int'(dcacheStall));
		end
		for (int i = 0; i < 9; i++) begin
			if (gotCount[i] != expCount[i]) begin
				reportMismatch(s, countName(i), expCount[i], gotCount[i]);
			end
		end
		if (validCnt != expCount[4]) begin
			reportMismatch(s, "setValid", expCount[4], validCnt);
		end
		if (clearCnt != expCount[4]) begin
			reportMismatch(s, "clearDirty", expCount[4], clearCnt);
		end
		// one LRU update per cached access
		if (lruCnt != expCount[0]) begin
			reportMismatch(s, "lruWriteEn", expCount[0], lruCnt);
		end
	endtask

	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, controller never returned to ready",
			watchdogCycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		memRW = 2'b00;
		atomic = 2'b00;
		exception = 1'b0;
		cacheable = 1'b0;
		cacheHit = 1'b0;
		victimDirty = 1'b0;
		stallW = 1'b0;
		$readmemh("dv/stimulus_input.txt", stimMem);
		watchdogCycles = watchdogLimit();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int s = 0; s < scenarioCount; s++) begin
			runScenario(s);
		end
		$display("%0d scenarios run, %0d errors", scenarioCount, errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- dv/stimulus_input.txt
// kind(1 read 2 write 3 amo) cacheable hit victimDirty exception stallWcycles ackDelay(ff random)
// expected: access miss readBeats writeBeats blockWrite wordWrite setDirty selUncached stallSeen
01 01 01 00 00 00 00  01 00 00 00 00 00 00 00 00  // read hit
02 01 01 00 00 00 00  01 00 00 00 00 01 01 00 00  // write hit
01 01 00 00 00 00 00  01 01 08 00 01 00 00 00 01  // read miss, clean victim
02 01 00 00 00 00 01  01 01 08 00 01 01 01 00 01  // write miss, clean victim
01 01 00 01 00 00 00  01 01 08 08 01 00 00 00 01  // read miss, dirty victim
02 01 00 01 00 00 ff  01 01 08 08 01 01 01 00 01  // write miss, dirty victim
03 01 00 00 00 00 ff  01 01 08 00 01 01 01 00 01  // amo miss, clean victim
03 01 00 01 00 00 02  01 01 08 08 01 01 01 00 01  // amo miss, dirty victim
01 00 00 00 00 00 00  00 00 01 00 00 00 00 01 01  // uncached read
02 00 00 00 00 00 03  00 00 00 01 00 00 00 00 01  // uncached write
01 00 00 00 00 05 ff  00 00 01 00 00 00 00 01 01  // uncached read, stallW
03 01 01 00 00 00 00  01 00 00 00 00 01 01 00 00  // amo hit
03 01 01 00 00 03 00  01 00 00 00 00 01 01 00 00  // amo hit, stallW
01 01 01 00 00 02 00  01 00 00 00 00 00 00 00 00  // read hit, stallW
02 01 01 00 01 00 00  00 00 00 00 00 00 00 00 00  // write hit, exception
01 01 00 00 01 00 00  00 00 00 00 00 00 00 00 00  // read miss, exception
02 01 01 00 00 04 00  01 00 00 00 00 01 01 00 00  // write hit, stallW
01 01 00 00 00 02 ff  01 01 08 00 01 00 00 00 01  // read miss, stallW during fetch
02 00 00 00 01 00 00  00 00 00 00 00 00 00 00 00  // uncached write, exception
03 01 00 01 00 28 00  01 01 08 08 01 01 01 00 01  // amo miss, dirty, stallW past read word

//--- hdl/beatCounter.sv
// bus beat counter for line fill and writeback
// flags the last beat of a line

`timescale 1ns/1ps

module beatCounter
	import cachePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cntEn,
	input  logic cntReset,
	output logic lastBeat
);

	logic [beatCountBits-1:0] beatCount;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			beatCount <= '0;
		end else if (cntReset) begin
			beatCount <= '0;
		end else if (cntEn) begin
			beatCount <= beatCount + 1'b1;
		end
	end

	assign lastBeat = (beatCount == beatCountBits'(beatsPerLine - 1));

	// the sequencer never restarts a line while a beat is being taken
	cntExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(cntEn && cntReset)
	) else $error("cntEn and cntReset high together");

endmodule

//--- hdl/cachePkg.sv
// shared definitions for the L1 data cache controller
// line geometry, decoded request classes, array address select

package cachePkg;

	////////////////////////////////////////////////////////////
	// line geometry
	////////////////////////////////////////////////////////////

	localparam int wordBits = 64;
	localparam int lineBits = 512;

	// one bus beat moves one word
	localparam int beatsPerLine = lineBits / wordBits;
	localparam int beatCountBits = $clog2(beatsPerLine);

	////////////////////////////////////////////////////////////
	// request classes and address select
	////////////////////////////////////////////////////////////

	// one class per processor request, at most one in flight
	typedef enum logic [2:0] {
		reqNone,
		reqReadHit,
		reqWriteHit,
		reqAmoHit,
		reqMiss,
		reqUncachedRead,
		reqUncachedWrite
	} reqClassType;

	// code 1 stays free, no replay address here
	typedef enum logic [1:0] {
		adrSelNext = 2'd0,
		adrSelHeld = 2'd2
	} adrSelType;

endpackage

//--- hdl/dcacheCtrl.sv
// data cache controller top level
// request decoder, controller FSM and beat counter

`timescale 1ns/1ps

module dcacheCtrl
	import cachePkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] memRW,
	input  logic [1:0] atomic,
	input  logic       exception,
	input  logic       cacheable,
	input  logic       cacheHit,
	input  logic       victimDirty,
	input  logic       stallW,
	input  logic       ahbAck,
	output logic       dcacheStall,
	output logic       committed,
	output logic       accessPulse,
	output logic       missPulse,
	output logic       ahbRead,
	output logic       ahbWrite,
	output adrSelType  selAdr,
	output logic       setValid,
	output logic       clearDirty,
	output logic       setDirty,
	output logic       wordWriteEn,
	output logic       blockWriteEn,
	output logic       selUncached,
	output logic       selEvict,
	output logic       lruWriteEn
);

	reqClassType reqClass;
	logic        cntEn;
	logic        cntReset;
	logic        lastBeat;

	requestDecode decoder (
		.memRW     (memRW),
		.atomic    (atomic),
		.cacheable (cacheable),
		.cacheHit  (cacheHit),
		.exception (exception),
		.reqClass  (reqClass)
	);

	missSequencer sequencer (
		.clk          (clk),
		.reset        (reset),
		.reqClass     (reqClass),
		.memRW        (memRW),
		.atomic       (atomic),
		.stallW       (stallW),
		.ahbAck       (ahbAck),
		.lastBeat     (lastBeat),
		.victimDirty  (victimDirty),
		.dcacheStall  (dcacheStall),
		.committed    (committed),
		.accessPulse  (accessPulse),
		.missPulse    (missPulse),
		.ahbRead      (ahbRead),
		.ahbWrite     (ahbWrite),
		.selAdr       (selAdr),
		.cntEn        (cntEn),
		.cntReset     (cntReset),
		.setValid     (setValid),
		.clearDirty   (clearDirty),
		.setDirty     (setDirty),
		.wordWriteEn  (wordWriteEn),
		.blockWriteEn (blockWriteEn),
		.selUncached  (selUncached),
		.selEvict     (selEvict),
		.lruWriteEn   (lruWriteEn)
	);

	// beats of the current line transfer
	beatCounter beatCount (
		.clk      (clk),
		.reset    (reset),
		.cntEn    (cntEn),
		.cntReset (cntReset),
		.lastBeat (lastBeat)
	);

endmodule

//--- hdl/missSequencer.sv
// data cache controller FSM
// hits, line fill with dirty writeback, uncached single beats,
// AMO completion and hold while writeback stage stalls

`timescale 1ns/1ps

module missSequencer
	import cachePkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  reqClassType reqClass,
	input  logic [1:0]  memRW,
	input  logic [1:0]  atomic,
	input  logic        stallW,
	input  logic        ahbAck,
	input  logic        lastBeat,
	input  logic        victimDirty,
	output logic        dcacheStall,
	output logic        committed,
	output logic        accessPulse,
	output logic        missPulse,
	output logic        ahbRead,
	output logic        ahbWrite,
	output adrSelType   selAdr,
	output logic        cntEn,
	output logic        cntReset,
	output logic        setValid,
	output logic        clearDirty,
	output logic        setDirty,
	output logic        wordWriteEn,
	output logic        blockWriteEn,
	output logic        selUncached,
	output logic        selEvict,
	output logic        lruWriteEn
);

	typedef enum logic [3:0] {
		stReady,
		stFetch,
		stFetchDone,
		stEvict,
		stBlockWrite,
		stReadWord,
		stReadDelay,
		stWriteWord,
		stUncachedRead,
		stUncachedReadDone,
		stUncachedWrite,
		stUncachedWriteDone,
		stCpuBusy,
		stBusyFinishAmo
	} stateType;

	stateType state;
	stateType nextState;
	logic     preCntEn;
	logic     amoReq;

	// only the miss path needs to tell an AMO from a plain store
	assign amoReq = atomic[1] & (&memRW);

	// a beat counts only when the bus takes it
	assign cntEn = preCntEn & ahbAck;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= stReady;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and strobes
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		dcacheStall = 1'b0;
		committed = 1'b0;
		accessPulse = 1'b0;
		missPulse = 1'b0;
		ahbRead = 1'b0;
		ahbWrite = 1'b0;
		selAdr = adrSelNext;
		preCntEn = 1'b0;
		cntReset = 1'b0;
		setValid = 1'b0;
		clearDirty = 1'b0;
		setDirty = 1'b0;
		wordWriteEn = 1'b0;
		blockWriteEn = 1'b0;
		selUncached = 1'b0;
		selEvict = 1'b0;
		lruWriteEn = 1'b0;

		case (state)
			stReady: begin
				nextState = stReady;
				case (reqClass)
					reqAmoHit: begin
						accessPulse = 1'b1;
						selAdr = adrSelHeld;
						// write half of the AMO waits for the writeback stage
						if (stallW) begin
							nextState = stBusyFinishAmo;
						end else begin
							wordWriteEn = 1'b1;
							setDirty = 1'b1;
							lruWriteEn = 1'b1;
						end
					end
					reqReadHit: begin
						accessPulse = 1'b1;
						lruWriteEn = 1'b1;
						if (stallW) begin
							nextState = stCpuBusy;
							selAdr = adrSelHeld;
						end
					end
					reqWriteHit: begin
						accessPulse = 1'b1;
						selAdr = adrSelHeld;
						wordWriteEn = 1'b1;
						setDirty = 1'b1;
						lruWriteEn = 1'b1;
						if (stallW) begin
							nextState = stCpuBusy;
						end
					end
					reqMiss: begin
						nextState = stFetch;
						cntReset = 1'b1;
						dcacheStall = 1'b1;
						accessPulse = 1'b1;
						missPulse = 1'b1;
					end
					reqUncachedWrite: begin
						nextState = stUncachedWrite;
						dcacheStall = 1'b1;
					end
					reqUncachedRead: begin
						nextState = stUncachedRead;
						dcacheStall = 1'b1;
					end
					default: begin
						nextState = stReady;
					end
				endcase
			end

			// line fill, one word per acknowledged beat
			stFetch: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				selAdr = adrSelHeld;
				ahbRead = 1'b1;
				preCntEn = 1'b1;
				if (lastBeat && ahbAck) begin
					nextState = stFetchDone;
				end
			end

			stFetchDone: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				selAdr = adrSelHeld;
				cntReset = 1'b1;
				nextState = victimDirty ? stEvict : stBlockWrite;
			end

			// victim goes out before the new line is written
			stEvict: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				selAdr = adrSelHeld;
				ahbWrite = 1'b1;
				selEvict = 1'b1;
				preCntEn = 1'b1;
				if (lastBeat && ahbAck) begin
					nextState = stBlockWrite;
				end
			end

			stBlockWrite: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				selAdr = adrSelHeld;
				blockWriteEn = 1'b1;
				setValid = 1'b1;
				clearDirty = 1'b1;
				nextState = stReadWord;
			end

			stReadWord: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				selAdr = adrSelHeld;
				if (memRW[0] && !amoReq) begin
					nextState = stWriteWord;
				end else begin
					nextState = stReadDelay;
				end
			end

			// memRW[1] still high here, the pipeline was stalled
			stReadDelay: begin
				committed = 1'b1;
				if (amoReq) begin
					selAdr = adrSelHeld;
					if (stallW) begin
						nextState = stBusyFinishAmo;
					end else begin
						wordWriteEn = 1'b1;
						setDirty = 1'b1;
						lruWriteEn = 1'b1;
						nextState = stReady;
					end
				end else begin
					lruWriteEn = 1'b1;
					if (stallW) begin
						nextState = stCpuBusy;
						selAdr = adrSelHeld;
					end else begin
						nextState = stReady;
					end
				end
			end

			stWriteWord: begin
				committed = 1'b1;
				selAdr = adrSelHeld;
				wordWriteEn = 1'b1;
				setDirty = 1'b1;
				lruWriteEn = 1'b1;
				nextState = stallW ? stCpuBusy : stReady;
			end

			////////////////////////////////////////////////////////////
			// uncached single beats
			////////////////////////////////////////////////////////////

			stUncachedRead: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				ahbRead = 1'b1;
				if (ahbAck) begin
					nextState = stUncachedReadDone;
				end
			end

			stUncachedReadDone: begin
				committed = 1'b1;
				selUncached = 1'b1;
				if (stallW) begin
					nextState = stCpuBusy;
					selAdr = adrSelHeld;
				end else begin
					nextState = stReady;
				end
			end

			stUncachedWrite: begin
				dcacheStall = 1'b1;
				committed = 1'b1;
				ahbWrite = 1'b1;
				if (ahbAck) begin
					nextState = stUncachedWriteDone;
				end
			end

			stUncachedWriteDone: begin
				committed = 1'b1;
				if (stallW) begin
					nextState = stCpuBusy;
					selAdr = adrSelHeld;
				end else begin
					nextState = stReady;
				end
			end

			// hold the result until the writeback stage moves
			stCpuBusy: begin
				committed = 1'b1;
				if (stallW) begin
					selAdr = adrSelHeld;
				end else begin
					nextState = stReady;
				end
			end

			stBusyFinishAmo: begin
				committed = 1'b1;
				selAdr = adrSelHeld;
				if (!stallW) begin
					wordWriteEn = 1'b1;
					setDirty = 1'b1;
					lruWriteEn = 1'b1;
					nextState = stReady;
				end
			end

			default: begin
				nextState = stReady;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// protocol checks
	////////////////////////////////////////////////////////////

	busOneDir: assert property (
		@(posedge clk) disable iff (reset)
		!(ahbRead && ahbWrite)
	) else $error("ahbRead and ahbWrite high together");

	arrayOneWrite: assert property (
		@(posedge clk) disable iff (reset)
		!(blockWriteEn && wordWriteEn)
	) else $error("block and word write in one cycle");

	// a line becomes valid only as it is written whole
	validWithBlock: assert property (
		@(posedge clk) disable iff (reset)
		setValid |-> blockWriteEn
	) else $error("setValid without blockWriteEn");

endmodule

//--- hdl/requestDecode.sv
// processor request classifier for the data cache controller
// hit, cacheability and exception are resolved here only

`timescale 1ns/1ps

module requestDecode
	import cachePkg::*;
(
	input  logic [1:0]  memRW,
	input  logic [1:0]  atomic,
	input  logic        cacheable,
	input  logic        cacheHit,
	input  logic        exception,
	output reqClassType reqClass
);

	logic readReq;
	logic writeReq;
	logic amoReq;
	logic anyReq;

	// memRW[1] read, memRW[0] write, both plus atomic[1] is an AMO
	assign readReq = memRW[1];
	assign writeReq = memRW[0];
	assign amoReq = atomic[1] & (&memRW);
	assign anyReq = (|memRW) | (|atomic);

	// priority order matters, AMO must win over plain read and write
	always_comb begin
		reqClass = reqNone;
		if (!anyReq || exception) begin
			reqClass = reqNone;
		end else if (cacheable && cacheHit && amoReq) begin
			reqClass = reqAmoHit;
		end else if (cacheable && cacheHit && readReq) begin
			reqClass = reqReadHit;
		end else if (cacheable && cacheHit && writeReq) begin
			reqClass = reqWriteHit;
		end else if (cacheable && !cacheHit && (readReq || writeReq)) begin
			reqClass = reqMiss;
		end else if (!cacheable && writeReq) begin
			reqClass = reqUncachedWrite;
		end else if (!cacheable && readReq) begin
			reqClass = reqUncachedRead;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the data cache controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dcacheCtrlTb -f verilog.f -o simDcacheCtrl
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simDcacheCtrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" sim.log; then
	exit 0
fi
exit 1

//--- verilog.f
hdl/cachePkg.sv
hdl/requestDecode.sv
hdl/beatCounter.sv
hdl/missSequencer.sv
hdl/dcacheCtrl.sv
dv/dcacheCtrlTb.sv
